// File: files.f
source/nice_pkg.sv
source/nice_seq.sv
source/nice_row_buf.sv
source/nice_mem_port.sv
source/nice_core.sv
bench/nice_mem_model.sv
bench/nice_core_tb.sv

// File: Bender.yml
package:
  name: nice_core

sources:
  - files:
      - source/nice_pkg.sv
      - source/nice_seq.sv
      - source/nice_row_buf.sv
      - source/nice_mem_port.sv
      - source/nice_core.sv
  - target: test
    files:
      - bench/nice_mem_model.sv
      - bench/nice_core_tb.sv

// File: bench/nice_core_tb.sv
// NICE coprocessor testbench
`timescale 1ns/1ps

module nice_core_tb;
  import nice_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam int          MAX_INST    = 20;
  localparam int          INST_CYCLES = 200;
  localparam int          N_RAND      = 6;
  localparam logic [31:0] SEED        = 32'h2766_2a22;
  localparam logic [31:0] RD_KEY      = 32'ha5c3_0f96;

  logic                         nice_clk;
  logic                         nice_rst_n;
  logic                         nice_req_valid;
  logic                         nice_req_ready;
  nice_req_t                    nice_req;
  logic                         nice_rsp_valid;
  logic                         nice_rsp_ready;
  logic [XLEN-1:0]              nice_rsp_rdat;
  logic                         nice_rsp_err;
  logic                         nice_icb_cmd_valid;
  logic                         nice_icb_cmd_ready;
  nice_icb_cmd_t                nice_icb_cmd;
  logic                         nice_icb_rsp_valid;
  logic                         nice_icb_rsp_ready;
  nice_icb_rsp_t                nice_icb_rsp;
  logic                         nice_mem_holdup;
  logic                         nice_active;
  logic                         inject_err;
  integer                       seed;
  logic [31:0]                  rand_base [N_RAND];
  nice_op_e                     rand_op;
  // Reference state for the instruction in flight
  nice_op_e                     exp_op;
  logic [XLEN-1:0]              exp_base;
  logic [XLEN-1:0]              exp_rdat;
  logic                         exp_err;
  logic [ROW_LEN-1:0][XLEN-1:0] exp_row;
  logic                         busy;
  int                           cmd_cnt;
  logic                         req_fire;
  logic                         cmd_fire;

  nice_core u_nice_core (
    .nice_clk           (nice_clk),
    .nice_rst_n         (nice_rst_n),
    .nice_req_valid     (nice_req_valid),
    .nice_req_ready     (nice_req_ready),
    .nice_req           (nice_req),
    .nice_rsp_valid     (nice_rsp_valid),
    .nice_rsp_ready     (nice_rsp_ready),
    .nice_rsp_rdat      (nice_rsp_rdat),
    .nice_rsp_err       (nice_rsp_err),
    .nice_icb_cmd_valid (nice_icb_cmd_valid),
    .nice_icb_cmd_ready (nice_icb_cmd_ready),
    .nice_icb_cmd       (nice_icb_cmd),
    .nice_icb_rsp_valid (nice_icb_rsp_valid),
    .nice_icb_rsp_ready (nice_icb_rsp_ready),
    .nice_icb_rsp       (nice_icb_rsp),
    .nice_mem_holdup    (nice_mem_holdup),
    .nice_active        (nice_active)
  );

  nice_mem_model #(.SEED(SEED), .RD_KEY(RD_KEY)) u_mem (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .cmd_valid  (nice_icb_cmd_valid),
    .cmd_ready  (nice_icb_cmd_ready),
    .cmd        (nice_icb_cmd),
    .rsp_valid  (nice_icb_rsp_valid),
    .rsp_ready  (nice_icb_rsp_ready),
    .rsp        (nice_icb_rsp),
    .inject_err (inject_err)
  );

  initial
  begin
    nice_clk = 1'b0;
    forever #(CLK_PERIOD / 2) nice_clk = ~nice_clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Word the memory returns for a read
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ RD_KEY;
  endfunction

  // R-type custom-3 word, rs1 x1 and rd x2
  function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd0, 5'd1, f3, 5'd2, OPC_CUSTOM3};
  endfunction

  function automatic logic [31:0] op_inst(input nice_op_e kind);
    case (kind)
      OP_LBUF:   return encode(F7_LBUF, F3_BUF);
      OP_SBUF:   return encode(F7_SBUF, F3_BUF);
      default:   return encode(F7_ROWSUM, F3_ROWSUM);
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  // Issue one instruction and wait for its result to transfer
  task automatic run_op(input nice_op_e kind, input logic [31:0] inst,
                        input logic [31:0] base, input logic inject);
    logic [31:0] sum;
    int          waited;
    sum = '0;
    for (int i = 0; i < ROW_LEN; i++)
      sum = sum + mem_word(base + WORD_BYTES * i);
    exp_op         <= kind;
    exp_base       <= base;
    exp_rdat       <= (kind == OP_ROWSUM) ? sum : '0;
    exp_err        <= inject || (kind == OP_ILLEGAL);
    inject_err     <= inject;
    nice_req_valid <= 1'b1;
    nice_req.inst  <= inst;
    nice_req.rs1   <= base;
    waited = 0;
    do
    begin
      @(posedge nice_clk);
      waited++;
      if (waited > INST_CYCLES)
        abort_run("request was not accepted in time");
    end
    while (!nice_req_ready);
    nice_req_valid <= 1'b0;
    inject_err     <= 1'b0;
    waited = 0;
    do
    begin
      @(posedge nice_clk);
      waited++;
      if (waited > INST_CYCLES)
        abort_run("no response arrived in time");
    end
    while (!(nice_rsp_valid && nice_rsp_ready));
    // Stored row as it landed in memory
    if (kind == OP_SBUF)
    begin
      for (int i = 0; i < ROW_LEN; i++)
        assert (u_mem.wr_log.exists(base + WORD_BYTES * i) &&
                u_mem.wr_log[base + WORD_BYTES * i] == exp_row[i])
          else report_mismatch("memory write log differs from buffer");
    end
    // Buffer contents after the instruction
    for (int i = 0; i < ROW_LEN; i++)
    begin
      if (kind == OP_LBUF)
        exp_row[i] = mem_word(base + WORD_BYTES * i);
      else if (kind == OP_ROWSUM)
        exp_row[i] = exp_row[i] + mem_word(base + WORD_BYTES * i);
    end
  endtask

  //////////////////////////////////////////////////
  // Transfer tracking
  //////////////////////////////////////////////////

  assign req_fire = nice_req_valid && nice_req_ready;
  assign cmd_fire = nice_icb_cmd_valid && nice_icb_cmd_ready;

  always @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      busy    <= 1'b0;
      cmd_cnt <= 0;
    end
    else if (req_fire)
    begin
      busy    <= 1'b1;
      cmd_cnt <= 0;
    end
    else
    begin
      if (cmd_fire)
        cmd_cnt <= cmd_cnt + 1;
      if (nice_rsp_valid && nice_rsp_ready)
        busy <= 1'b0;
    end
  end

  // Random result back-pressure
  always @(posedge nice_clk)
    nice_rsp_ready <= ($random(seed) & 3) != 0;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge nice_clk) $rose(nice_rst_n) |->
    (nice_req_ready && !nice_rsp_valid && !nice_icb_cmd_valid && !nice_mem_holdup))
    else report_mismatch("outputs wrong right after reset");

  // Address steps one word per command from rs1
  a_cmd_fields: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    cmd_fire |-> (nice_icb_cmd.addr == exp_base + WORD_BYTES * cmd_cnt &&
                  nice_icb_cmd.size == SIZE_WORD &&
                  nice_icb_cmd.read == (exp_op != OP_SBUF) && cmd_cnt < ROW_LEN))
    else report_mismatch("memory command fields or count wrong");

  a_store_data: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (cmd_fire && exp_op == OP_SBUF) |-> nice_icb_cmd.wdata == exp_row[cmd_cnt])
    else report_mismatch("store data differs from buffer entry");

  a_cmd_total: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_rsp_valid |-> cmd_cnt == ((exp_op == OP_ILLEGAL) ? 0 : ROW_LEN))
    else report_mismatch("wrong number of memory commands");

  a_rsp_value: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_rsp_valid |-> (nice_rsp_rdat == exp_rdat && nice_rsp_err == exp_err))
    else report_mismatch("response payload wrong");

  // Holdup covers exactly the memory phase of a legal instruction
  a_holdup: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_mem_holdup == (busy && exp_op != OP_ILLEGAL && !nice_rsp_valid))
    else report_mismatch("holdup wrong for the instruction phase");

  // Active over the whole instruction and while a request waits
  a_active: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_active == (busy || nice_req_valid))
    else report_mismatch("active status wrong");

  a_icb_rsp_ready: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_icb_rsp_ready)
    else report_mismatch("memory response not accepted");

  // Illegal answers next cycle and never touches memory
  a_illegal_time: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (req_fire && exp_op == OP_ILLEGAL) |=> nice_rsp_valid)
    else report_mismatch("illegal response not one cycle after acceptance");

  a_illegal_quiet: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (busy && exp_op == OP_ILLEGAL) |-> !nice_icb_cmd_valid)
    else report_mismatch("memory command for an illegal instruction");

  a_rsp_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (nice_rsp_valid && !nice_rsp_ready) |=>
      (nice_rsp_valid && $stable(nice_rsp_rdat) && $stable(nice_rsp_err)))
    else report_mismatch("response changed under back-pressure");

  a_no_req: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_rsp_valid |-> !nice_req_ready)
    else report_mismatch("request ready while a response is pending");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin
    seed           = SEED;
    nice_rst_n     = 1'b0;
    nice_req_valid = 1'b0;
    nice_req       = '0;
    nice_rsp_ready = 1'b0;
    inject_err     = 1'b0;
    exp_op         = OP_NONE;
    exp_base       = '0;
    exp_rdat       = '0;
    exp_err        = 1'b0;
    for (int k = 0; k < N_RAND; k++)
      rand_base[k] = $random(seed) & 32'hffff_fffc;
    repeat (8) @(posedge nice_clk);
    nice_rst_n <= 1'b1;
    @(posedge nice_clk);
    run_op(OP_LBUF, op_inst(OP_LBUF), 32'h0000_1000, 1'b0);
    run_op(OP_SBUF, op_inst(OP_SBUF), 32'h0000_2000, 1'b0);
    // High addresses make the sum wrap
    run_op(OP_ROWSUM, op_inst(OP_ROWSUM), 32'hf000_3000, 1'b0);
    run_op(OP_SBUF, op_inst(OP_SBUF), 32'h0000_4000, 1'b0);
    // Custom-3 with unknown func7, then a plain add
    run_op(OP_ILLEGAL, encode(7'h7f, F3_BUF), 32'h0, 1'b0);
    run_op(OP_ILLEGAL, 32'h0020_81b3, 32'h0, 1'b0);
    run_op(OP_LBUF, op_inst(OP_LBUF), 32'h0000_5000, 1'b1);
    run_op(OP_SBUF, op_inst(OP_SBUF), 32'h0000_6000, 1'b0);
    for (int k = 0; k < N_RAND; k++)
    begin
      case (k % 3)
        0:       rand_op = OP_ROWSUM;
        1:       rand_op = OP_SBUF;
        default: rand_op = OP_LBUF;
      endcase
      run_op(rand_op, op_inst(rand_op), rand_base[k], 1'b0);
    end
    repeat (4) @(posedge nice_clk);
    $display("TB PASSED");
    $finish;
  end

  // Watchdog over the longest allowed run
  initial
  begin
    #(MAX_INST * INST_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before all instructions finished");
  end

endmodule

// File: bench/nice_mem_model.sv
// NICE bench memory responder
`timescale 1ns/1ps

module nice_mem_model #(
  parameter logic [31:0] SEED   = 32'h0,
  parameter logic [31:0] RD_KEY = 32'h0
) (
  input  logic                    nice_clk,
  input  logic                    nice_rst_n,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  nice_pkg::nice_icb_cmd_t cmd,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output nice_pkg::nice_icb_rsp_t rsp,
  input  logic                    inject_err
);
  import nice_pkg::*;

  integer          seed;
  // Responses owed, in command order
  nice_icb_rsp_t   pend_q[$];
  nice_icb_rsp_t   entry;
  // Write log by address
  logic [XLEN-1:0] wr_log [logic [XLEN-1:0]];
  logic            err_pending;
  int              gap;

  initial
  begin
    seed        = SEED;
    cmd_ready   = 1'b0;
    rsp_valid   = 1'b0;
    rsp         = '0;
    err_pending = 1'b0;
    gap         = 0;
  end

  always @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      cmd_ready   <= 1'b0;
      rsp_valid   <= 1'b0;
      err_pending = 1'b0;
      gap         = 0;
      pend_q.delete();
    end
    else
    begin
      // Random command back-pressure
      cmd_ready <= ($random(seed) & 3) != 0;
      // Head leaves on transfer, then a random pause
      if (rsp_valid && rsp_ready)
      begin
        void'(pend_q.pop_front());
        gap = $random(seed) & 3;
      end
      if (cmd_valid && cmd_ready)
      begin
        entry.rdata = cmd.read ? (cmd.addr ^ RD_KEY) : '0;
        entry.err   = cmd.read && err_pending;
        if (cmd.read)
          err_pending = 1'b0;
        else
          wr_log[cmd.addr] = cmd.wdata;
        pend_q.push_back(entry);
      end
      // Armed error hits the next read
      if (inject_err)
        err_pending = 1'b1;
      // Offered response holds until taken
      if (!(rsp_valid && !rsp_ready))
      begin
        if (gap > 0 || pend_q.size() == 0)
        begin
          rsp_valid <= 1'b0;
          if (gap > 0)
            gap = gap - 1;
        end
        else
        begin
          rsp_valid <= 1'b1;
          rsp       <= pend_q[0];
        end
      end
    end
  end

endmodule

// File: source/nice_core.sv
// NICE coprocessor top level
`timescale 1ns/1ps

module nice_core (
  input  logic                          nice_clk,
  input  logic                          nice_rst_n,
  // Instruction request
  input  logic                          nice_req_valid,
  output logic                          nice_req_ready,
  input  nice_pkg::nice_req_t           nice_req,
  // Instruction result
  output logic                          nice_rsp_valid,
  input  logic                          nice_rsp_ready,
  output logic [nice_pkg::XLEN-1:0]     nice_rsp_rdat,
  output logic                          nice_rsp_err,
  // Memory command
  output logic                          nice_icb_cmd_valid,
  input  logic                          nice_icb_cmd_ready,
  output nice_pkg::nice_icb_cmd_t       nice_icb_cmd,
  // Memory response
  input  logic                          nice_icb_rsp_valid,
  output logic                          nice_icb_rsp_ready,
  input  nice_pkg::nice_icb_rsp_t       nice_icb_rsp,
  // Status towards the core pipeline
  output logic                          nice_mem_holdup,
  output logic                          nice_active
);
  import nice_pkg::*;

  // Strobes from the sequencer
  nice_op_e             op;
  logic                 acc_start;
  logic                 cmd_fire;
  logic                 rsp_fire;
  logic [ROW_IDX_W-1:0] cmd_idx;
  logic [ROW_IDX_W-1:0] rsp_idx;
  // Row buffer results
  logic [XLEN-1:0]      rd_word;
  logic [XLEN-1:0]      sum_value;
  logic                 sum_done;

  // Responses are always taken, in command order
  assign nice_icb_rsp_ready = 1'b1;

  nice_seq u_nice_seq (
    .nice_clk           (nice_clk),
    .nice_rst_n         (nice_rst_n),
    .nice_req_valid     (nice_req_valid),
    .nice_req_ready     (nice_req_ready),
    .nice_req           (nice_req),
    .nice_rsp_valid     (nice_rsp_valid),
    .nice_rsp_ready     (nice_rsp_ready),
    .nice_rsp_rdat      (nice_rsp_rdat),
    .nice_rsp_err       (nice_rsp_err),
    .nice_icb_cmd_valid (nice_icb_cmd_valid),
    .nice_icb_cmd_ready (nice_icb_cmd_ready),
    .nice_icb_rsp_valid (nice_icb_rsp_valid),
    .icb_err            (nice_icb_rsp.err),
    .nice_mem_holdup    (nice_mem_holdup),
    .nice_active        (nice_active),
    .sum_done           (sum_done),
    .sum_value          (sum_value),
    .op                 (op),
    .acc_start          (acc_start),
    .cmd_fire           (cmd_fire),
    .rsp_fire           (rsp_fire),
    .cmd_idx            (cmd_idx),
    .rsp_idx            (rsp_idx)
  );

  nice_row_buf u_nice_row_buf (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .op         (op),
    .acc_start  (acc_start),
    .rsp_fire   (rsp_fire),
    .rsp_idx    (rsp_idx),
    .cmd_idx    (cmd_idx),
    .rsp_data   (nice_icb_rsp.rdata),
    .rd_word    (rd_word),
    .sum_value  (sum_value),
    .sum_done   (sum_done)
  );

  nice_mem_port u_nice_mem_port (
    .nice_clk     (nice_clk),
    .nice_rst_n   (nice_rst_n),
    .op           (op),
    .acc_start    (acc_start),
    .nice_req     (nice_req),
    .cmd_fire     (cmd_fire),
    .rd_word      (rd_word),
    .nice_icb_cmd (nice_icb_cmd)
  );

endmodule

// File: source/nice_mem_port.sv
// NICE memory command port
`timescale 1ns/1ps

module nice_mem_port (
  input  logic                      nice_clk,
  input  logic                      nice_rst_n,
  input  nice_pkg::nice_op_e        op,
  input  logic                      acc_start,
  input  nice_pkg::nice_req_t       nice_req,
  input  logic                      cmd_fire,
  input  logic [nice_pkg::XLEN-1:0] rd_word,
  output nice_pkg::nice_icb_cmd_t   nice_icb_cmd
);
  import nice_pkg::*;

  logic [XLEN-1:0] addr_q;
  logic            is_store;

  //////////////////////////////////////////////////
  // Address register
  //////////////////////////////////////////////////

  // Base from rs1 at acceptance, then one word per issued command
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      addr_q <= '0;
    else if (acc_start)
      addr_q <= nice_req.rs1;
    else if (cmd_fire)
      addr_q <= addr_q + XLEN'(WORD_BYTES);
  end

  //////////////////////////////////////////////////
  // Command fields
  //////////////////////////////////////////////////

  // Only sbuf writes
  assign is_store = (op == OP_SBUF);

  always_comb
  begin
    nice_icb_cmd.addr  = addr_q;
    nice_icb_cmd.read  = !is_store;
    // Write data follows the command index through rd_word
    nice_icb_cmd.wdata = is_store ? rd_word : '0;
    // Always full words
    nice_icb_cmd.size  = SIZE_WORD;
  end

endmodule

// File: source/nice_row_buf.sv
// NICE row buffer and accumulator
`timescale 1ns/1ps

module nice_row_buf (
  input  logic                           nice_clk,
  input  logic                           nice_rst_n,
  input  nice_pkg::nice_op_e             op,
  input  logic                           acc_start,
  input  logic                           rsp_fire,
  input  logic [nice_pkg::ROW_IDX_W-1:0] rsp_idx,
  input  logic [nice_pkg::ROW_IDX_W-1:0] cmd_idx,
  input  logic [nice_pkg::XLEN-1:0]      rsp_data,
  output logic [nice_pkg::XLEN-1:0]      rd_word,
  output logic [nice_pkg::XLEN-1:0]      sum_value,
  output logic                           sum_done
);
  import nice_pkg::*;

  logic [XLEN-1:0]      row_q [ROW_LEN];
  logic                 lbuf_we;
  logic                 rcv_valid_q;
  logic [XLEN-1:0]      rcv_data_q;
  logic [ROW_IDX_W-1:0] rcv_idx_q;
  logic [XLEN-1:0]      acc_q;

  // Load writes straight from the memory response
  assign lbuf_we = rsp_fire && (op == OP_LBUF);

  //////////////////////////////////////////////////
  // Receive stage for rowsum
  //////////////////////////////////////////////////

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      rcv_valid_q <= 1'b0;
    else
      rcv_valid_q <= rsp_fire && (op == OP_ROWSUM);
  end

  // Word and its row position, one cycle behind the response
  always_ff @(posedge nice_clk)
  begin
    if (rsp_fire)
    begin
      rcv_data_q <= rsp_data;
      rcv_idx_q  <= rsp_idx;
    end
  end

  //////////////////////////////////////////////////
  // Storage and sum
  //////////////////////////////////////////////////

  always_ff @(posedge nice_clk)
  begin
    if (lbuf_we)
      row_q[rsp_idx] <= rsp_data;
    else if (rcv_valid_q)
      row_q[rcv_idx_q] <= row_q[rcv_idx_q] + rcv_data_q;
  end

  // Running sum includes the word now in the receive register
  assign sum_value = acc_q + rcv_data_q;

  always_ff @(posedge nice_clk)
  begin
    if (acc_start)
      acc_q <= '0;
    else if (rcv_valid_q)
      acc_q <= sum_value;
  end

  // High while the last word of the row is being added
  assign sum_done = rcv_valid_q && (rcv_idx_q == ROW_IDX_W'(ROW_LEN - 1));

  // Store data, quiet once the row is exhausted
  assign rd_word = (cmd_idx < ROW_IDX_W'(ROW_LEN)) ? row_q[cmd_idx] : '0;

  // A pending rowsum add must never spill into a store
  a_no_write_in_sbuf: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (op == OP_SBUF) |-> !rcv_valid_q)
    else $error("row buffer written during sbuf");

endmodule

// File: source/nice_seq.sv
// NICE instruction sequencer
`timescale 1ns/1ps

module nice_seq (
  input  logic                          nice_clk,
  input  logic                          nice_rst_n,
  input  logic                          nice_req_valid,
  output logic                          nice_req_ready,
  input  nice_pkg::nice_req_t           nice_req,
  output logic                          nice_rsp_valid,
  input  logic                          nice_rsp_ready,
  output logic [nice_pkg::XLEN-1:0]     nice_rsp_rdat,
  output logic                          nice_rsp_err,
  output logic                          nice_icb_cmd_valid,
  input  logic                          nice_icb_cmd_ready,
  input  logic                          nice_icb_rsp_valid,
  input  logic                          icb_err,
  output logic                          nice_mem_holdup,
  output logic                          nice_active,
  input  logic                          sum_done,
  input  logic [nice_pkg::XLEN-1:0]     sum_value,
  output nice_pkg::nice_op_e            op,
  output logic                          acc_start,
  output logic                          cmd_fire,
  output logic                          rsp_fire,
  output logic [nice_pkg::ROW_IDX_W-1:0] cmd_idx,
  output logic [nice_pkg::ROW_IDX_W-1:0] rsp_idx
);
  import nice_pkg::*;

  nice_state_e          state_q;
  nice_state_e          state_d;
  nice_op_e             op_dec;
  logic [6:0]           opcode;
  logic [2:0]           func3;
  logic [6:0]           func7;
  logic                 req_fire;
  logic                 out_fire;
  logic                 rsp_last;
  logic [ROW_IDX_W-1:0] cmd_cnt_q;
  logic [ROW_IDX_W-1:0] rsp_cnt_q;
  logic                 err_q;
  logic [XLEN-1:0]      rdat_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign opcode = nice_req.inst[6:0];
  assign func3  = nice_req.inst[14:12];
  assign func7  = nice_req.inst[31:25];

  // Anything not recognised is answered with an error
  always_comb
  begin
    op_dec = OP_ILLEGAL;
    if (opcode == OPC_CUSTOM3)
    begin
      if (func3 == F3_BUF && func7 == F7_LBUF)
        op_dec = OP_LBUF;
      else if (func3 == F3_BUF && func7 == F7_SBUF)
        op_dec = OP_SBUF;
      else if (func3 == F3_ROWSUM && func7 == F7_ROWSUM)
        op_dec = OP_ROWSUM;
    end
  end

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // Requests only in idle, independent of memory readiness
  assign nice_req_ready = (state_q == ST_IDLE);
  assign req_fire       = nice_req_valid & nice_req_ready;
  assign acc_start      = req_fire & (op_dec != OP_ILLEGAL);
  assign out_fire       = nice_rsp_valid & nice_rsp_ready;

  // Command issue stops once the whole row is out
  assign nice_icb_cmd_valid = (state_q == ST_MEM) && (cmd_cnt_q < ROW_IDX_W'(ROW_LEN));
  assign cmd_fire           = nice_icb_cmd_valid & nice_icb_cmd_ready;
  assign rsp_fire           = (state_q == ST_MEM) & nice_icb_rsp_valid;
  assign rsp_last           = rsp_fire && (rsp_cnt_q == ROW_IDX_W'(ROW_LEN - 1));

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (req_fire)
          state_d = (op_dec == OP_ILLEGAL) ? ST_RESP : ST_MEM;
      end
      ST_MEM:
      begin
        // Rowsum still has the receive stage and final add ahead
        if (rsp_last)
          state_d = (op == OP_ROWSUM) ? ST_SUM : ST_RESP;
      end
      ST_SUM:
      begin
        if (sum_done)
          state_d = ST_RESP;
      end
      ST_RESP:
      begin
        if (out_fire)
          state_d = ST_IDLE;
      end
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      state_q   <= ST_IDLE;
      op        <= OP_NONE;
      cmd_cnt_q <= '0;
      rsp_cnt_q <= '0;
      err_q     <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Operation is held until the result is taken
      if (req_fire)
        op <= op_dec;
      else if (out_fire)
        op <= OP_NONE;
      if (acc_start)
        cmd_cnt_q <= '0;
      else if (cmd_fire)
        cmd_cnt_q <= cmd_cnt_q + 1'b1;
      if (acc_start)
        rsp_cnt_q <= '0;
      else if (rsp_fire)
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
      // Sticky error over the whole instruction
      if (req_fire)
        err_q <= (op_dec == OP_ILLEGAL);
      else if (rsp_fire && icb_err)
        err_q <= 1'b1;
    end
  end

  // Result data, zero unless a rowsum completes
  always_ff @(posedge nice_clk)
  begin
    if (req_fire)
      rdat_q <= '0;
    else if (state_q == ST_SUM && sum_done)
      rdat_q <= sum_value;
  end

  assign nice_rsp_valid  = (state_q == ST_RESP);
  assign nice_rsp_rdat   = rdat_q;
  assign nice_rsp_err    = err_q;
  assign nice_mem_holdup = (state_q == ST_MEM) || (state_q == ST_SUM);
  assign nice_active     = (state_q != ST_IDLE) || nice_req_valid;
  assign cmd_idx         = cmd_cnt_q;
  assign rsp_idx         = rsp_cnt_q;

  // Memory commands belong to the three memory instructions only
  a_cmd_in_mem: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_icb_cmd_valid |-> (op inside {OP_LBUF, OP_SBUF, OP_ROWSUM}))
    else $error("memory command outside a memory instruction");

  // Whole row is issued before the result is offered
  a_row_issued: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (nice_rsp_valid && op != OP_ILLEGAL) |-> (cmd_cnt_q == ROW_IDX_W'(ROW_LEN)))
    else $error("result offered before the row was issued");

endmodule

// File: source/nice_pkg.sv
// NICE coprocessor shared definitions
package nice_pkg;

  //////////////////////////////////////////////////
  // Widths and row geometry
  //////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN       = 32;
  // Words held in one row
  localparam int unsigned ROW_LEN    = 3;
  localparam int unsigned ROW_IDX_W  = 2;
  // Byte step between consecutive words
  localparam int unsigned WORD_BYTES = 4;
  // Memory size code for a full word
  localparam logic [1:0]  SIZE_WORD  = 2'd2;

  //////////////////////////////////////////////////
  // Instruction encoding
  //////////////////////////////////////////////////

  // Custom-3 major opcode, R-type only
  localparam logic [6:0]  OPC_CUSTOM3 = 7'h7b;
  localparam logic [2:0]  F3_BUF      = 3'b010;
  localparam logic [2:0]  F3_ROWSUM   = 3'b110;
  localparam logic [6:0]  F7_LBUF     = 7'b000_0001;
  localparam logic [6:0]  F7_SBUF     = 7'b000_0010;
  localparam logic [6:0]  F7_ROWSUM   = 7'b000_0110;

  // Decoded operation
  typedef enum logic [2:0] {
    OP_NONE,
    OP_LBUF,
    OP_SBUF,
    OP_ROWSUM,
    OP_ILLEGAL
  } nice_op_e;

  // Sequencer state
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM,
    ST_SUM,
    ST_RESP
  } nice_state_e;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] rs1;
  } nice_req_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            read;
    logic [XLEN-1:0] wdata;
    logic [1:0]      size;
  } nice_icb_cmd_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } nice_icb_rsp_t;

endpackage
